//--- dataRam.sv
`timescale 1ns/10ps
`include "prBus_params.svh"

module dataRam (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] wbAdr,
	input  logic [31:0] wbDatW,
	input  logic [3:0]  wbSel,
	input  logic        wbWe,
	input  logic        wbStb,
	output logic [31:0] wbDatR,
	output logic        wbAck
);

	localparam int IDXW = $clog2(`RAM_WORDS);

	logic [31:0]     mem [`RAM_WORDS];
	logic [IDXW-1:0] idx;
	logic            access;

	assign idx    = wbAdr[IDXW+1:2]; // Word index modulo RAM size
	assign access = wbStb && !wbAck;  // First strobe cycle only

	always_ff @(posedge clk) begin
		if (rst)
			wbAck <= 1'b0;
		else
			wbAck <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (wbWe) begin
				for (int b = 0; b < 4; b++) begin
					if (wbSel[b])
						mem[idx][8*b +: 8] <= wbDatW[8*b +: 8]; // Lane write
				end
			end
			wbDatR <= mem[idx];
		end
	end

endmodule

//--- devSystem.sv
`timescale 1ns/10ps

module devSystem
	import prBusPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  memOp_t   opIn,
	input  logic     opValid,
	output logic     opReady,
	output loadRes_t loadRes,
	output logic     loadValid,
	output excInfo_t exc,
	output logic     excValid,
	output logic     HWInt
);

	busReq_t     req;
	logic        reqValid;
	logic        reqFull;
	busRsp_t     rsp;
	logic        rspValid;
	logic [31:0] wbAdr;
	logic [31:0] wbDatW;
	logic [3:0]  wbSel;
	logic        wbWe;
	logic        ramStb;
	logic [31:0] ramDatR;
	logic        ramAck;
	logic        tmrStb;
	logic [31:0] tmrDatR;
	logic        tmrAck;

	memStage memStage_inst (
		.clk       (clk),
		.rst       (rst),
		.opIn      (opIn),
		.opValid   (opValid),
		.opReady   (opReady),
		.reqFull   (reqFull),
		.reqOut    (req),
		.reqValid  (reqValid),
		.rspIn     (rsp),
		.rspValid  (rspValid),
		.loadRes   (loadRes),
		.loadValid (loadValid),
		.exc       (exc),
		.excValid  (excValid)
	);

	// Cyc and shared Stb frame the cycle; devices see their own strobe
	prBridge prBridge_inst (
		.clk      (clk),
		.rst      (rst),
		.reqIn    (req),
		.reqValid (reqValid),
		.reqFull  (reqFull),
		.rspOut   (rsp),
		.rspValid (rspValid),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.wbSel    (wbSel),
		.wbWe     (wbWe),
		.wbCyc    (),
		.wbStb    (),
		.ramStb   (ramStb),
		.ramDatR  (ramDatR),
		.ramAck   (ramAck),
		.tmrStb   (tmrStb),
		.tmrDatR  (tmrDatR),
		.tmrAck   (tmrAck)
	);

	dataRam dataRam_inst (
		.clk    (clk),
		.rst    (rst),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbSel  (wbSel),
		.wbWe   (wbWe),
		.wbStb  (ramStb),
		.wbDatR (ramDatR),
		.wbAck  (ramAck)
	);

	timerDevice timerDevice_inst (
		.clk    (clk),
		.rst    (rst),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbSel  (wbSel),
		.wbWe   (wbWe),
		.wbStb  (tmrStb),
		.wbDatR (tmrDatR),
		.wbAck  (tmrAck),
		.HWInt  (HWInt)
	);

endmodule

//--- devSystem_input.txt
// kind size signed address storeData dest expected, all hex; kind 0 load 1 store 2 await HWInt
// kind 3 drain then expect HWInt 4 set max idle gap; size 0 byte 1 half 2 word
4 0 0 00000000 00000003 00 00000000 // Idle gaps up to 3 cycles
3 0 0 00000000 00000000 00 00000000 // HWInt low out of reset
1 2 0 00000010 DEADBEEF 00 00000000
1 2 0 00000014 12345678 00 00000000
0 2 0 00000010 00000000 05 DEADBEEF // Second store left the first alone
0 2 0 00000014 00000000 06 12345678
1 2 0 00000020 00000000 00 00000000
1 0 0 00000020 FFFFFF81 00 00000000 // Only the low byte counts
1 0 0 00000021 0000007F 00 00000000
1 1 0 00000022 1111C3D4 00 00000000 // Upper halfword lanes
0 2 0 00000020 00000000 07 C3D47F81
0 0 1 00000020 00000000 08 FFFFFF81
0 0 0 00000020 00000000 09 00000081
0 0 1 00000021 00000000 0A 0000007F
0 0 1 00000023 00000000 0B FFFFFFC3
0 1 1 00000022 00000000 0C FFFFC3D4
0 1 0 00000022 00000000 0D 0000C3D4
0 1 0 00000011 00000000 0E 00000004 // Odd halfword load
0 2 0 00000012 00000000 0F 00000004
1 2 0 00000016 AAAAAAAA 00 00000005
1 1 0 00000013 BBBBBBBB 00 00000005
0 2 0 00000010 00000000 10 DEADBEEF // Faulting stores never landed
0 2 0 00000014 00000000 11 12345678
1 2 0 00000000 11223344 00 00000000
1 2 0 00001000 CAFEF00D 00 00000000 // Unmapped, same word index as 0
0 2 0 00001000 00000000 12 00000000
0 2 0 00000000 00000000 13 11223344
1 2 0 00007F04 00000020 00 00000000 // Preset 32
1 2 0 00007F00 00000003 00 00000000 // Enable and interrupt enable
2 0 0 00000034 00000000 00 00000000 // Preset plus 20 cycles
0 2 0 00007F08 00000000 14 00000000 // One-shot count parks at zero
3 0 0 00000000 00000000 00 00000001
1 2 0 00007F00 00000000 00 00000000
0 2 0 00007F00 00000000 15 00000000
3 0 0 00000000 00000000 00 00000000 // Ctrl write dropped HWInt
4 0 0 00000000 00000000 00 00000000 // Back-to-back burst
1 2 0 00000030 A5A5A5A5 00 00000000
1 2 0 00000034 5A5A5A5A 00 00000000
1 2 0 00000038 0F0F0F0F 00 00000000
1 2 0 0000003C F0F0F0F0 00 00000000
0 2 0 00000030 00000000 16 A5A5A5A5
0 2 0 00000034 00000000 17 5A5A5A5A
0 2 0 00000038 00000000 18 0F0F0F0F
0 2 0 0000003C 00000000 19 F0F0F0F0
0 0 1 00000030 00000000 1A FFFFFFA5
0 1 0 00000036 00000000 1B 00005A5A
4 0 0 00000000 00000006 00 00000000
0 2 0 00000010 00000000 1C DEADBEEF
0 0 0 0000003F 00000000 1D 000000F0
0 2 0 00000020 00000000 1E C3D47F81
0 1 1 0000003A 00000000 1F 00000F0F
3 0 0 00000000 00000000 00 00000000

//--- list.f
+incdir+.
prBusPkg.sv
pipeFifo.sv
memStage.sv
prBridge.sv
dataRam.sv
timerDevice.sv
devSystem.sv
tb_devSystem.sv

//--- memStage.sv
`timescale 1ns/10ps

module memStage
	import prBusPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  memOp_t   opIn,
	input  logic     opValid,
	output logic     opReady,
	input  logic     reqFull,
	output busReq_t  reqOut,
	output logic     reqValid,
	input  busRsp_t  rspIn,
	input  logic     rspValid,
	output loadRes_t loadRes,
	output logic     loadValid,
	output excInfo_t exc,
	output logic     excValid
);

	localparam logic [4:0] EXC_ADEL = 5'd4; // Address error on load
	localparam logic [4:0] EXC_ADES = 5'd5; // Address error on store

	logic        accept;
	logic        misaligned;
	logic [3:0]  laneBe;
	logic [31:0] laneData;
	logic [31:0] rawShift;
	logic [31:0] extValue;

	assign opReady = !reqFull; // Pipeline stalls on bridge space
	assign accept  = opValid && opReady;

	////////////////////////////////////////////////////////////////////////////
	// Request side

	always_comb begin
		case (opIn.size)
			SIZE_HALF: misaligned = opIn.addr[0];
			SIZE_WORD: misaligned = |opIn.addr[1:0];
			default:   misaligned = 1'b0; // Bytes never fault
		endcase
	end

	// Byte enables and lane shift
	always_comb begin
		case (opIn.size)
			SIZE_BYTE: begin
				laneBe   = 4'b0001 << opIn.addr[1:0];
				laneData = {24'b0, opIn.data[7:0]} << {opIn.addr[1:0], 3'b000};
			end
			SIZE_HALF: begin
				laneBe   = opIn.addr[1] ? 4'b1100 : 4'b0011;
				laneData = {16'b0, opIn.data[15:0]} << {opIn.addr[1], 4'b0000};
			end
			default: begin
				laneBe   = 4'b1111;
				laneData = opIn.data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reqValid <= 1'b0;
			excValid <= 1'b0;
		end else begin
			reqValid <= accept && !misaligned; // Faulting ops never reach the bus
			excValid <= accept && misaligned;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			reqOut.we           <= (opIn.kind == MEM_STORE);
			reqOut.wordAddr     <= opIn.addr[31:2];
			reqOut.be           <= laneBe;
			reqOut.data         <= laneData;
			reqOut.tag.dest     <= opIn.dest;
			reqOut.tag.size     <= opIn.size;
			reqOut.tag.isSigned <= opIn.isSigned;
			reqOut.tag.lowAddr  <= opIn.addr[1:0];
			exc.code            <= (opIn.kind == MEM_STORE) ? EXC_ADES : EXC_ADEL;
			exc.badAddr         <= opIn.addr;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Load extraction

	assign rawShift = rspIn.data >> {rspIn.tag.lowAddr, 3'b000}; // Lane down to bit 0

	always_comb begin
		case (rspIn.tag.size)
			SIZE_BYTE: extValue = {{24{rspIn.tag.isSigned & rawShift[7]}}, rawShift[7:0]};
			SIZE_HALF: extValue = {{16{rspIn.tag.isSigned & rawShift[15]}}, rawShift[15:0]};
			default:   extValue = rspIn.data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			loadValid <= 1'b0;
		end else begin
			loadValid <= rspValid; // Always accepted
		end
	end

	always_ff @(posedge clk) begin
		if (rspValid) begin
			loadRes.dest  <= rspIn.tag.dest;
			loadRes.value <= extValue;
		end
	end

	// A stalled op stays on the inputs until it is taken
	opHeldOnStall: assert property (@(posedge clk) disable iff (rst)
		opValid && !opReady |=> opValid && $stable(opIn));

endmodule

//--- pipeFifo.sv
`timescale 1ns/10ps
`include "prBus_params.svh"

module pipeFifo
	import prBusPkg::*;
#(
	parameter type payload_t = busReq_t
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t wrData,
	input  logic     wrEn,
	output payload_t rdData,
	input  logic     rdEn,
	output logic     full,
	output logic     empty
);

	localparam int DEPTH = `PR_FIFO_DEPTH;
	localparam int PTRW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t        store [DEPTH];
	logic [PTRW-1:0] wrPtr;
	logic [PTRW-1:0] rdPtr;
	logic [PTRW:0]   count; // Occupancy

	// Wrap also for depths that are no power of two
	function automatic logic [PTRW-1:0] nextPtr(input logic [PTRW-1:0] ptr);
		return (ptr == PTRW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn)
				wrPtr <= nextPtr(wrPtr);
			if (rdEn)
				rdPtr <= nextPtr(rdPtr);
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or simultaneous push/pop
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wrEn)
			store[wrPtr] <= wrData;
	end

	assign rdData = store[rdPtr]; // Head visible before pop
	assign full   = (count == (PTRW + 1)'(DEPTH));
	assign empty  = (count == '0);

	noOverflow: assert property (@(posedge clk) disable iff (rst) wrEn |-> !full);
	noUnderflow: assert property (@(posedge clk) disable iff (rst) rdEn |-> !empty);

endmodule

//--- prBridge.sv
`timescale 1ns/10ps
`include "prBus_params.svh"

module prBridge
	import prBusPkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  busReq_t     reqIn,
	input  logic        reqValid,
	output logic        reqFull,
	output busRsp_t     rspOut,
	output logic        rspValid,
	output logic [31:0] wbAdr,
	output logic [31:0] wbDatW,
	output logic [3:0]  wbSel,
	output logic        wbWe,
	output logic        wbCyc,
	output logic        wbStb,
	output logic        ramStb,
	input  logic [31:0] ramDatR,
	input  logic        ramAck,
	output logic        tmrStb,
	input  logic [31:0] tmrDatR,
	input  logic        tmrAck
);

	localparam int          DEPTH    = `PR_FIFO_DEPTH;
	localparam int          CNTW     = $clog2(DEPTH + 1);
	localparam logic [31:0] RAM_SIZE = 32'(`RAM_WORDS * 4);

	busReq_t     headReq;
	logic        reqEmpty;
	logic        reqFifoFull;
	logic [CNTW-1:0] reqCount; // Mirrors request FIFO occupancy
	busRsp_t     rspPush;
	logic        rspWr;
	logic        rspFull;
	logic        rspEmpty;
	logic [31:0] headAddr;
	logic        hitRam;
	logic        hitTmr;
	logic        startReq;
	logic        selRam;   // Device of the running cycle
	loadTag_t    curTag;
	logic        busAck;
	logic [31:0] busDatR;

	pipeFifo #(.payload_t(busReq_t)) reqFifo (
		.clk    (clk),
		.rst    (rst),
		.wrData (reqIn),
		.wrEn   (reqValid),
		.rdData (headReq),
		.rdEn   (startReq),
		.full   (reqFifoFull),
		.empty  (reqEmpty)
	);

	pipeFifo #(.payload_t(busRsp_t)) rspFifo (
		.clk    (clk),
		.rst    (rst),
		.wrData (rspPush),
		.wrEn   (rspWr),
		.rdData (rspOut),
		.rdEn   (rspValid), // Memory stage never stalls
		.full   (rspFull),
		.empty  (rspEmpty)
	);

	assign rspValid = !rspEmpty;

	// Request in the stage register still needs a slot
	always_ff @(posedge clk) begin
		if (rst)
			reqCount <= '0;
		else if (reqValid && !startReq)
			reqCount <= reqCount + 1'b1;
		else if (!reqValid && startReq)
			reqCount <= reqCount - 1'b1;
	end

	assign reqFull = reqFifoFull || (reqValid && reqCount == CNTW'(DEPTH - 1));

	////////////////////////////////////////////////////////////////////////////
	// Decode and Wishbone master

	assign headAddr = {headReq.wordAddr, 2'b00};
	assign hitRam   = (headAddr - `RAM_BASE) < RAM_SIZE;  // Wraps below base
	assign hitTmr   = (headAddr - `TIMER_BASE) < 32'(`TIMER_SPAN);

	// Reads wait for response room, writes never do
	assign startReq = !wbCyc && !reqEmpty && (headReq.we || !rspFull);

	assign busAck  = wbStb && (selRam ? ramAck : tmrAck);
	assign busDatR = selRam ? ramDatR : tmrDatR;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
		end else if (busAck) begin
			wbCyc <= 1'b0; // Idle cycle follows
			wbStb <= 1'b0;
		end else if (startReq && (hitRam || hitTmr)) begin
			wbCyc <= 1'b1;
			wbStb <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (startReq) begin
			wbAdr  <= headAddr;
			wbDatW <= headReq.data;
			wbSel  <= headReq.be;
			wbWe   <= headReq.we;
			selRam <= hitRam;
			curTag <= headReq.tag;
		end
	end

	assign ramStb = wbStb && selRam;
	assign tmrStb = wbStb && !selRam;

	// Read data on ack, or zero for an unmapped read; unmapped writes vanish
	assign rspWr = (busAck && !wbWe) ||
		(startReq && !headReq.we && !hitRam && !hitTmr);

	always_comb begin
		rspPush.data = busAck ? busDatR : 32'b0;
		rspPush.tag  = busAck ? curTag : headReq.tag;
	end

	// Strobe reaches the one device whose window holds the bus address
	strobeOneHot: assert property (@(posedge clk) disable iff (rst)
		wbStb |-> (ramStb == ((wbAdr - `RAM_BASE) < RAM_SIZE)) &&
			(tmrStb == ((wbAdr - `TIMER_BASE) < 32'(`TIMER_SPAN))));

	// Devices only answer a strobe of the previous cycle
	ackAfterStb: assert property (@(posedge clk) disable iff (rst)
		(ramAck || tmrAck) |-> $past(wbStb));

endmodule

//--- prBusPkg.sv
package prBusPkg;

	typedef enum logic {
		MEM_LOAD  = 1'b0,
		MEM_STORE = 1'b1
	} memKind_e;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} memSize_e;

	// One load or store handed over by the pipeline
	typedef struct packed {
		memKind_e    kind;
		memSize_e    size;
		logic        isSigned; // lb/lh vs lbu/lhu
		logic [31:0] addr;
		logic [31:0] data;     // Store data before lane placement
		logic [4:0]  dest;     // Writeback register
	} memOp_t;

	// Everything needed to finish a load once the word is back
	typedef struct packed {
		logic [4:0] dest;
		memSize_e   size;
		logic       isSigned;
		logic [1:0] lowAddr;
	} loadTag_t;

	typedef struct packed {
		logic        we;
		logic [29:0] wordAddr; // Address bits 31:2
		logic [3:0]  be;
		logic [31:0] data;     // Already on its byte lanes
		loadTag_t    tag;
	} busReq_t;

	typedef struct packed {
		logic [31:0] data; // Raw word from the device
		loadTag_t    tag;
	} busRsp_t;

	typedef struct packed {
		logic [4:0]  dest;
		logic [31:0] value;
	} loadRes_t;

	typedef struct packed {
		logic [4:0]  code;    // MIPS ExcCode
		logic [31:0] badAddr;
	} excInfo_t;

endpackage

//--- prBus_params.svh
`ifndef PR_BUS_PARAMS_SVH
`define PR_BUS_PARAMS_SVH

// Entries per bridge FIFO on request and response side alike
`define PR_FIFO_DEPTH 4

// Device map
`define RAM_WORDS 16
`define RAM_BASE 32'h0000_0000
`define TIMER_BASE 32'h0000_7F00
`define TIMER_SPAN 12 // ctrl, preset, count

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the devSystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_devSystem -f list.f -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- tb_devSystem.sv
`timescale 1ns/10ps

module tb_devSystem
	import prBusPkg::*;
();

	localparam int MAX_WORDS = 512; // Room for 73 operations
	localparam int COLS      = 7;   // Seven columns per operation

	logic     clk = 1'b0;
	logic     rst;
	memOp_t   opIn;
	logic     opValid;
	logic     opReady;
	loadRes_t loadRes;
	logic     loadValid;
	excInfo_t exc;
	logic     excValid;
	logic     HWInt;

	logic [31:0] stim [0:MAX_WORDS-1];
	loadRes_t    loadQ [$]; // Expected loads in acceptance order
	excInfo_t    excQ [$];
	int          nOps;
	int          maxGap;
	int          valueErrors;
	int          otherErrors;
	integer      seed;
	logic        loaded = 1'b0;

	devSystem devSystem_inst (
		.clk       (clk),
		.rst       (rst),
		.opIn      (opIn),
		.opValid   (opValid),
		.opReady   (opReady),
		.loadRes   (loadRes),
		.loadValid (loadValid),
		.exc       (exc),
		.excValid  (excValid),
		.HWInt     (HWInt)
	);

	always #10 clk = ~clk; // 20 ns period

	////////////////////////////////////////////////////////////////////////////
	// Driving side

	// Holds the op until opReady and queues its expected result
	task automatic issueOp(input int base);
		memOp_t   op;
		loadRes_t expLoad;
		excInfo_t expExc;
		logic     bad;
		op.kind     = memKind_e'(stim[base][0]);
		op.size     = memSize_e'(stim[base+1][1:0]);
		op.isSigned = stim[base+2][0];
		op.addr     = stim[base+3];
		op.data     = stim[base+4];
		op.dest     = stim[base+5][4:0];
		bad = (op.size == SIZE_HALF && op.addr[0]) ||
			(op.size == SIZE_WORD && op.addr[1:0] != 2'b00);
		opIn    = op;
		opValid = 1'b1;
		@(negedge clk);
		while (!opReady)
			@(negedge clk); // Stalled by bridge
		if (bad) begin
			expExc.code    = stim[base+6][4:0];
			expExc.badAddr = op.addr;
			excQ.push_back(expExc);
		end else if (op.kind == MEM_LOAD) begin
			expLoad.dest  = op.dest;
			expLoad.value = stim[base+6];
			loadQ.push_back(expLoad);
		end
		@(posedge clk); // Transfer edge
		#2;
		opValid = 1'b0;
	endtask

	task automatic awaitInterrupt(input logic [31:0] limit);
		int cycles;
		cycles = 0;
		while (!HWInt && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		assert (HWInt) else begin
			$display("HWInt did not rise within %0d cycles of enabling the timer", limit);
			otherErrors++;
		end
		@(posedge clk);
		#2;
	endtask

	// Drains outstanding results so earlier writes have landed
	task automatic drainAndCheckInt(input logic expInt);
		while (loadQ.size() != 0 || excQ.size() != 0)
			@(negedge clk);
		@(negedge clk);
		assert (HWInt == expInt) else begin
			$display("** Error at %0t: HWInt expected %0b, got %0b", $time, expInt, HWInt);
			valueErrors++;
		end
		@(posedge clk);
		#2;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result checking

	task automatic checkLoad();
		loadRes_t expLoad;
		assert (loadQ.size() != 0) else begin
			$display("A load result arrived at %0t with no load outstanding", $time);
			otherErrors++;
		end
		if (loadQ.size() != 0) begin
			expLoad = loadQ.pop_front();
			assert (loadRes.dest == expLoad.dest) else begin
				$display("** Error at %0t: loadRes.dest expected %0d, got %0d",
					$time, expLoad.dest, loadRes.dest);
				valueErrors++;
			end
			assert (loadRes.value == expLoad.value) else begin
				$display("** Error at %0t: loadRes.value expected %h, got %h",
					$time, expLoad.value, loadRes.value);
				valueErrors++;
			end
		end
	endtask

	task automatic checkExc();
		excInfo_t expExc;
		assert (excQ.size() != 0) else begin
			$display("An exception was reported at %0t for an aligned operation", $time);
			otherErrors++;
		end
		if (excQ.size() != 0) begin
			expExc = excQ.pop_front();
			assert (exc.code == expExc.code) else begin
				$display("** Error at %0t: exc.code expected %0d, got %0d",
					$time, expExc.code, exc.code);
				valueErrors++;
			end
			assert (exc.badAddr == expExc.badAddr) else begin
				$display("** Error at %0t: exc.badAddr expected %h, got %h",
					$time, expExc.badAddr, exc.badAddr);
				valueErrors++;
			end
		end
	endtask

	always @(negedge clk) begin // Registered outputs settled by now
		if (!rst && loadValid)
			checkLoad();
		if (!rst && excValid)
			checkExc();
	end

	initial begin
		wait (loaded);
		repeat (nOps * 40 + 2000) @(posedge clk);
		$display("Timeout after %0d cycles with results still missing", nOps * 40 + 2000);
		$display("Simulation finished: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int base;
		int gap;
		rst         = 1'b1;
		opIn        = '0;
		opValid     = 1'b0;
		seed        = 40;
		maxGap      = 0;
		valueErrors = 0;
		otherErrors = 0;
		for (int i = 0; i < MAX_WORDS; i++)
			stim[i] = 32'hFFFF_FFFF; // End marker
		$readmemh("devSystem_input.txt", stim);
		nOps = 0;
		while ((nOps + 1) * COLS <= MAX_WORDS && stim[nOps*COLS] != 32'hFFFF_FFFF)
			nOps++;
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < nOps; i++) begin
			base = i * COLS;
			case (stim[base])
				32'd0, 32'd1: begin
					gap = $unsigned($random(seed)) % (maxGap + 1);
					repeat (gap) begin
						@(posedge clk);
						#2;
					end
					issueOp(base);
				end
				32'd2:   awaitInterrupt(stim[base+3]);
				32'd3:   drainAndCheckInt(stim[base+6][0]);
				32'd4:   maxGap = stim[base+4];
				default: begin
					$display("Line %0d of the data file has unknown kind %0d", i, stim[base]);
					otherErrors++;
				end
			endcase
		end
		while (loadQ.size() != 0 || excQ.size() != 0)
			@(negedge clk);
		repeat (20) @(negedge clk); // Room for stray results
		$display("Errors: %0d value, %0d other", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- timerDevice.sv
`timescale 1ns/10ps
`include "prBus_params.svh"

module timerDevice (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] wbAdr,
	input  logic [31:0] wbDatW,
	input  logic [3:0]  wbSel,
	input  logic        wbWe,
	input  logic        wbStb,
	output logic [31:0] wbDatR,
	output logic        wbAck,
	output logic        HWInt
);

	localparam logic [1:0] OFF_CTRL   = 2'd0;
	localparam logic [1:0] OFF_PRESET = 2'd1;
	localparam logic [1:0] OFF_COUNT  = 2'd2; // Read-only

	logic [2:0]  ctrl; // {autoReload, intEn, enable}
	logic [31:0] preset;
	logic [31:0] count;
	logic [31:0] offset;
	logic [31:0] byteMask;
	logic [31:0] presetNext;
	logic        access;
	logic        wrCtrl;
	logic        wrPreset;
	logic        hitZero;

	assign offset   = wbAdr - `TIMER_BASE;
	assign access   = wbStb && !wbAck;
	assign wrCtrl   = access && wbWe && offset[3:2] == OFF_CTRL;
	assign wrPreset = access && wbWe && offset[3:2] == OFF_PRESET;
	assign byteMask = {{8{wbSel[3]}}, {8{wbSel[2]}}, {8{wbSel[1]}}, {8{wbSel[0]}}};

	assign presetNext = (preset & ~byteMask) | (wbDatW & byteMask);
	assign hitZero    = ctrl[0] && count == 32'd1; // Last decrement

	////////////////////////////////////////////////////////////////////////////
	// Counter and interrupt

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl   <= '0;
			preset <= '0;
			count  <= '0;
			HWInt  <= 1'b0;
		end else begin
			if (wrCtrl)
				ctrl <= (ctrl & ~byteMask[2:0]) | (wbDatW[2:0] & byteMask[2:0]);
			if (wrPreset) begin
				preset <= presetNext;
				count  <= presetNext; // Preset write restarts count
			end else if (hitZero) begin
				count <= ctrl[2] ? preset : 32'd0;
			end else if (ctrl[0] && count != 32'd0) begin
				count <= count - 1'b1;
			end
			if (wrCtrl)
				HWInt <= 1'b0; // Acknowledge by ctrl write
			else if (hitZero && ctrl[1])
				HWInt <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			wbAck <= 1'b0;
		else
			wbAck <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (offset[3:2])
				OFF_CTRL:   wbDatR <= {29'b0, ctrl};
				OFF_PRESET: wbDatR <= preset;
				OFF_COUNT:  wbDatR <= count;
				default:    wbDatR <= 32'b0; // Past the window
			endcase
		end
	end

endmodule
